// ==== hw/axi_cmd_bridge.sv ====
module axi_cmd_bridge (
    input  logic                 aclk,
    input  logic                 aresetn,
    // aw channel
    input  axi_cmd_pkg::id_t     awid,
    input  axi_cmd_pkg::addr_t   awaddr,
    input  axi_cmd_pkg::len_t    awlen,
    input  axi_cmd_pkg::size_t   awsize,
    input  logic [1:0]           awburst,
    input  logic                 awvalid,
    output logic                 awready,
    // w channel
    input  axi_cmd_pkg::data_t   wdata,
    input  axi_cmd_pkg::strb_t   wstrb,
    input  logic                 wlast,
    input  logic                 wvalid,
    output logic                 wready,
    // ar channel
    input  axi_cmd_pkg::id_t     arid,
    input  axi_cmd_pkg::addr_t   araddr,
    input  axi_cmd_pkg::len_t    arlen,
    input  axi_cmd_pkg::size_t   arsize,
    input  logic [1:0]           arburst,
    input  logic                 arvalid,
    output logic                 arready,
    // command fifo push side
    output axi_cmd_pkg::addr_t   cmd_addr,
    output axi_cmd_pkg::data_t   cmd_data,
    output logic                 cmd_write,
    output axi_cmd_pkg::size_t   cmd_size,
    output axi_cmd_pkg::cmd_id_t cmd_id,
    output logic                 cmd_push,
    input  logic                 cmd_full
);
    import axi_cmd_pkg::*;

    // awburst and arburst are ignored, every burst walks as incr
    bridge_state_t state;
    logic          start;
    logic          beat_issue;
    addr_t         beat_addr;
    size_t         beat_size;
    id_t           beat_id;
    logic          read_last;

    burst_ctrl burst_ctrl_i (
        .aclk       (aclk),
        .aresetn    (aresetn),
        .awvalid    (awvalid),
        .wvalid     (wvalid),
        .wlast      (wlast),
        .arvalid    (arvalid),
        .cmd_full   (cmd_full),
        .read_last  (read_last),
        .awready    (awready),
        .wready     (wready),
        .arready    (arready),
        .start      (start),
        .beat_issue (beat_issue),
        .state      (state)
    );

    burst_tracker burst_tracker_i (
        .aclk       (aclk),
        .aresetn    (aresetn),
        .start      (start),
        .beat_issue (beat_issue),
        .state      (state),
        .awid       (awid),
        .awaddr     (awaddr),
        .awlen      (awlen),
        .awsize     (awsize),
        .arid       (arid),
        .araddr     (araddr),
        .arlen      (arlen),
        .arsize     (arsize),
        .beat_addr  (beat_addr),
        .beat_size  (beat_size),
        .beat_id    (beat_id),
        .read_last  (read_last)
    );

    cmd_register cmd_register_i (
        .aclk       (aclk),
        .aresetn    (aresetn),
        .beat_issue (beat_issue),
        .state      (state),
        .wdata      (wdata),
        .wstrb      (wstrb),
        .wlast      (wlast),
        .beat_addr  (beat_addr),
        .beat_size  (beat_size),
        .beat_id    (beat_id),
        .read_last  (read_last),
        .cmd_addr   (cmd_addr),
        .cmd_data   (cmd_data),
        .cmd_write  (cmd_write),
        .cmd_size   (cmd_size),
        .cmd_id     (cmd_id),
        .cmd_push   (cmd_push)
    );

endmodule

// ==== hw/axi_cmd_macros.svh ====
`ifndef AXI_CMD_MACROS_SVH
`define AXI_CMD_MACROS_SVH

// axi slave port geometry
`define AXI_ADDR_W 32
`define AXI_DATA_W 64

// one strobe bit per data byte
`define AXI_STRB_W 8

`define AXI_ID_W   8
`define AXI_LEN_W  8

// log2 of bytes per beat
`define AXI_SIZE_W 3

`endif

// ==== hw/axi_cmd_pkg.sv ====
`include "axi_cmd_macros.svh"

package axi_cmd_pkg;

    typedef enum logic [1:0] {
        IDLE,
        WRITE,
        READ
    } bridge_state_t;

    typedef logic [`AXI_ADDR_W-1:0] addr_t;
    typedef logic [`AXI_DATA_W-1:0] data_t;
    typedef logic [`AXI_STRB_W-1:0] strb_t;
    typedef logic [`AXI_ID_W-1:0]   id_t;
    typedef logic [`AXI_LEN_W-1:0]  len_t;
    typedef logic [`AXI_SIZE_W-1:0] size_t;

    // last-beat flag sits above the id
    typedef logic [`AXI_ID_W:0]     cmd_id_t;

endpackage

// ==== hw/burst_ctrl.sv ====
module burst_ctrl (
    input  logic                       aclk,
    input  logic                       aresetn,
    input  logic                       awvalid,
    input  logic                       wvalid,
    input  logic                       wlast,
    input  logic                       arvalid,
    input  logic                       cmd_full,
    input  logic                       read_last,
    output logic                       awready,
    output logic                       wready,
    output logic                       arready,
    output logic                       start,
    output logic                       beat_issue,
    output axi_cmd_pkg::bridge_state_t state
);
    import axi_cmd_pkg::*;

    bridge_state_t state_next;
    logic          aw_fire;
    logic          ar_fire;
    logic          w_fire;

    // address channels open only from idle, writes win a tie
    assign awready = (state == IDLE) && !cmd_full;
    assign arready = (state == IDLE) && !cmd_full && !awvalid;
    assign wready  = (state == WRITE) && !cmd_full;

    assign aw_fire = awvalid && awready;
    assign ar_fire = arvalid && arready;
    assign w_fire  = wvalid && wready;

    assign start = aw_fire || ar_fire;

    // read beats need only room downstream
    assign beat_issue = w_fire || ((state == READ) && !cmd_full);

    always_comb begin
        state_next = state;
        case (state)
            IDLE: begin
                if (aw_fire) begin
                    state_next = WRITE;
                end else if (ar_fire) begin
                    state_next = READ;
                end
            end
            WRITE: begin
                // master's wlast ends the burst
                if (w_fire && wlast) begin
                    state_next = IDLE;
                end
            end
            READ: begin
                if (beat_issue && read_last) begin
                    state_next = IDLE;
                end
            end
            default: begin
                state_next = IDLE;
            end
        endcase
    end

    always_ff @(posedge aclk or negedge aresetn) begin
        if (!aresetn) begin
            state <= IDLE;
        end else begin
            state <= state_next;
        end
    end

    // master holds aw valid until it is accepted
    a_aw_valid_hold: assert property (
        @(posedge aclk) disable iff (!aresetn)
        (awvalid && !awready) |=> awvalid
    );

endmodule

// ==== hw/burst_tracker.sv ====
module burst_tracker (
    input  logic                       aclk,
    input  logic                       aresetn,
    input  logic                       start,
    input  logic                       beat_issue,
    input  axi_cmd_pkg::bridge_state_t state,
    input  axi_cmd_pkg::id_t           awid,
    input  axi_cmd_pkg::addr_t         awaddr,
    input  axi_cmd_pkg::len_t          awlen,
    input  axi_cmd_pkg::size_t         awsize,
    input  axi_cmd_pkg::id_t           arid,
    input  axi_cmd_pkg::addr_t         araddr,
    input  axi_cmd_pkg::len_t          arlen,
    input  axi_cmd_pkg::size_t         arsize,
    output axi_cmd_pkg::addr_t         beat_addr,
    output axi_cmd_pkg::size_t         beat_size,
    output axi_cmd_pkg::id_t           beat_id,
    output logic                       read_last
);
    import axi_cmd_pkg::*;

    id_t   aw_id_q;
    addr_t aw_addr_q;
    len_t  aw_len_q;
    size_t aw_size_q;
    id_t   ar_id_q;
    addr_t ar_addr_q;
    len_t  ar_len_q;
    size_t ar_size_q;
    len_t  beat_cnt;
    addr_t base_addr;
    len_t  burst_len;
    addr_t beat_offset;

    // both headers land on start, the state entered picks one
    always_ff @(posedge aclk) begin
        if (start) begin
            aw_id_q   <= awid;
            aw_addr_q <= awaddr;
            aw_len_q  <= awlen;
            aw_size_q <= awsize;
            ar_id_q   <= arid;
            ar_addr_q <= araddr;
            ar_len_q  <= arlen;
            ar_size_q <= arsize;
        end
    end

    always_ff @(posedge aclk or negedge aresetn) begin
        if (!aresetn) begin
            beat_cnt <= '0;
        end else if (start) begin
            beat_cnt <= '0;
        end else if (beat_issue) begin
            beat_cnt <= beat_cnt + 1'b1;
        end
    end

    always_comb begin
        if (state == WRITE) begin
            base_addr = aw_addr_q;
            burst_len = aw_len_q;
            beat_size = aw_size_q;
            beat_id   = aw_id_q;
        end else begin
            base_addr = ar_addr_q;
            burst_len = ar_len_q;
            beat_size = ar_size_q;
            beat_id   = ar_id_q;
        end
    end

    // fixed bursts step like incr
    assign beat_offset = addr_t'(beat_cnt) << beat_size;
    assign beat_addr   = base_addr + beat_offset;
    assign read_last   = (beat_cnt == burst_len);

    a_cnt_in_burst: assert property (
        @(posedge aclk) disable iff (!aresetn)
        (state != IDLE) |-> (beat_cnt <= burst_len)
    );

endmodule

// ==== hw/cmd_register.sv ====
`include "axi_cmd_macros.svh"

module cmd_register (
    input  logic                       aclk,
    input  logic                       aresetn,
    input  logic                       beat_issue,
    input  axi_cmd_pkg::bridge_state_t state,
    input  axi_cmd_pkg::data_t         wdata,
    input  axi_cmd_pkg::strb_t         wstrb,
    input  logic                       wlast,
    input  axi_cmd_pkg::addr_t         beat_addr,
    input  axi_cmd_pkg::size_t         beat_size,
    input  axi_cmd_pkg::id_t           beat_id,
    input  logic                       read_last,
    output axi_cmd_pkg::addr_t         cmd_addr,
    output axi_cmd_pkg::data_t         cmd_data,
    output logic                       cmd_write,
    output axi_cmd_pkg::size_t         cmd_size,
    output axi_cmd_pkg::cmd_id_t       cmd_id,
    output logic                       cmd_push
);
    import axi_cmd_pkg::*;

    data_t wdata_masked;
    logic  is_write;
    logic  beat_last;

    // zero every byte lane whose strobe is off
    always_comb begin
        for (int i = 0; i < `AXI_STRB_W; i++) begin
            wdata_masked[8*i +: 8] = wstrb[i] ? wdata[8*i +: 8] : 8'h00;
        end
    end

    assign is_write  = (state == WRITE);
    assign beat_last = is_write ? wlast : read_last;

    always_ff @(posedge aclk) begin
        if (beat_issue) begin
            cmd_addr  <= beat_addr;
            cmd_size  <= beat_size;
            cmd_write <= is_write;
            cmd_data  <= is_write ? wdata_masked : '0;
            cmd_id    <= {beat_last, beat_id};
        end
    end

    always_ff @(posedge aclk or negedge aresetn) begin
        if (!aresetn) begin
            cmd_push <= 1'b0;
        end else begin
            cmd_push <= beat_issue;
        end
    end

endmodule

// ==== run.sh ====
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -f sources.f --top-module axi_cmd_bridge_tb \
    -o axi_cmd_bridge_sim \
    && ./obj_dir/axi_cmd_bridge_sim > sim.log 2>&1 \
    || { cat sim.log 2>/dev/null; echo "build or simulation did not complete"; exit 1; }
cat sim.log
grep -q "Some tests failed" sim.log && exit 1
exit 0

// ==== sources.f ====
+incdir+hw
hw/axi_cmd_pkg.sv
hw/burst_ctrl.sv
hw/burst_tracker.sv
hw/cmd_register.sv
hw/axi_cmd_bridge.sv
tb/axi_cmd_bridge_tb.sv

// ==== tb/axi_cmd_bridge_tb.sv ====
`include "axi_cmd_macros.svh"

module axi_cmd_bridge_tb;
    import axi_cmd_pkg::*;

    localparam int TIMEOUT = 1000;
    localparam int CMD_W = `AXI_ADDR_W + `AXI_DATA_W + 1 + `AXI_SIZE_W + `AXI_ID_W + 1;

    typedef logic [CMD_W-1:0] cmd_t;

    logic    aclk;
    logic    aresetn;
    id_t     awid;
    addr_t   awaddr;
    len_t    awlen;
    size_t   awsize;
    logic [1:0] awburst;
    logic    awvalid;
    logic    awready;
    data_t   wdata;
    strb_t   wstrb;
    logic    wlast;
    logic    wvalid;
    logic    wready;
    id_t     arid;
    addr_t   araddr;
    len_t    arlen;
    size_t   arsize;
    logic [1:0] arburst;
    logic    arvalid;
    logic    arready;
    addr_t   cmd_addr;
    data_t   cmd_data;
    logic    cmd_write;
    size_t   cmd_size;
    cmd_id_t cmd_id;
    logic    cmd_push;
    logic    cmd_full;

    cmd_t        got_q[$];
    cmd_t        exp_q[$];
    int          got_done = 0;
    int          exp_done = 0;
    int          errors = 0;
    int          push_errors = 0;
    int          timeouts = 0;
    logic        full_seen = 1'b0;
    logic        full_run = 1'b0;
    logic [31:0] lfsr = 32'hea5f75b5;

    axi_cmd_bridge axi_cmd_bridge_i (.*);

    initial begin
        aclk = 1'b0;
        forever begin
            #5 aclk = ~aclk;
        end
    end

    // record every push, flag one that follows a full cycle
    always @(negedge aclk) begin
        if (cmd_push) begin
            got_q.push_back({cmd_addr, cmd_data, cmd_write, cmd_size, cmd_id});
            if (full_seen) begin
                push_errors++;
                $display("Error at time %0t: command pushed after a cycle with cmd_full high",
                         $time);
            end
        end
        full_seen = cmd_full;
    end

    // galois lfsr, one step per bit taken
    function automatic logic [63:0] rand_bits(input int n);
        logic [63:0] r;
        r = '0;
        for (int k = 0; k < n; k++) begin
            r = {r[62:0], lfsr[0]};
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
        end
        return r;
    endfunction

    function automatic data_t lane_mask(input data_t d, input strb_t s);
        data_t keep;
        for (int b = 0; b < `AXI_STRB_W; b++) begin
            keep[8*b +: 8] = {8{s[b]}};
        end
        return d & keep;
    endfunction

    function automatic cmd_t make_cmd(input addr_t a, input data_t d, input logic w,
                                      input size_t s, input logic last, input id_t id);
        return {a, d, w, s, last, id};
    endfunction

    function automatic logic ready_of(input int ch);
        return (ch == 0) ? awready : ((ch == 1) ? wready : arready);
    endfunction

    // valid is already up, hold it until the ready edge
    task automatic wait_ready(input int ch, input string what);
        int cycles;
        cycles = 0;
        @(negedge aclk);
        while (!ready_of(ch) && cycles < TIMEOUT) begin
            @(negedge aclk);
            cycles++;
        end
        if (!ready_of(ch)) begin
            timeouts++;
            $display("Timeout: %s was not accepted within %0d cycles", what, TIMEOUT);
        end
        @(posedge aclk);
        #1;
    endtask

    task automatic send_aw(input id_t id, input addr_t addr, input len_t len, input size_t size);
        awid = id;
        awaddr = addr;
        awlen = len;
        awsize = size;
        awburst = 2'b01;
        awvalid = 1'b1;
        wait_ready(0, "write address");
        awvalid = 1'b0;
    endtask

    task automatic send_ar(input id_t id, input addr_t addr, input len_t len, input size_t size);
        arid = id;
        araddr = addr;
        arlen = len;
        arsize = size;
        arburst = 2'b01;
        arvalid = 1'b1;
        wait_ready(2, "read address");
        arvalid = 1'b0;
    endtask

    task automatic write_burst(input id_t id, input addr_t addr, input len_t len,
                               input size_t size, input logic rand_strb);
        data_t d;
        strb_t s;
        addr_t a;
        send_aw(id, addr, len, size);
        a = addr;
        for (int i = 0; i <= int'(len); i++) begin
            // no zero bytes, so a masked lane always shows
            d = data_t'(rand_bits(64)) | 64'h0101_0101_0101_0101;
            s = rand_strb ? strb_t'(rand_bits(8)) : '1;
            exp_q.push_back(make_cmd(a, lane_mask(d, s), 1'b1, size, i == int'(len), id));
            // next beat sits one transfer size further on
            a = a + (addr_t'(1) << size);
            wdata = d;
            wstrb = s;
            wlast = (i == int'(len));
            wvalid = 1'b1;
            wait_ready(1, "write data");
        end
        wvalid = 1'b0;
        wlast = 1'b0;
    endtask

    function automatic void expect_read(input id_t id, input addr_t addr, input len_t len,
                                        input size_t size);
        addr_t a;
        a = addr;
        for (int i = 0; i <= int'(len); i++) begin
            exp_q.push_back(make_cmd(a, '0, 1'b0, size, i == int'(len), id));
            a = a + (addr_t'(1) << size);
        end
    endfunction

    task automatic check_cmds(input string name);
        int cycles;
        int n;
        cycles = 0;
        while (got_q.size() - got_done < exp_q.size() - exp_done && cycles < TIMEOUT) begin
            @(negedge aclk);
            cycles++;
        end
        // a few idle cycles to catch extra pushes
        repeat (4) begin
            @(negedge aclk);
        end
        @(posedge aclk);
        #1;
        if (got_q.size() - got_done != exp_q.size() - exp_done) begin
            errors++;
            $display("Error at time %0t: %s gave %0d commands, expected %0d", $time, name,
                     got_q.size() - got_done, exp_q.size() - exp_done);
        end
        n = got_q.size() - got_done;
        if (exp_q.size() - exp_done < n) begin
            n = exp_q.size() - exp_done;
        end
        for (int i = 0; i < n; i++) begin
            if (got_q[got_done + i] !== exp_q[exp_done + i]) begin
                errors++;
                $display("Error at time %0t: %s command %0d is %h, expected %h", $time, name,
                         i, got_q[got_done + i], exp_q[exp_done + i]);
            end
        end
        got_done = got_q.size();
        exp_done = exp_q.size();
    endtask

    task automatic toggle_full();
        int hold;
        while (full_run) begin
            cmd_full = (rand_bits(1) != 64'd0);
            hold = int'(rand_bits(2)) + 1;
            repeat (hold) begin
                @(posedge aclk);
            end
            #1;
        end
        cmd_full = 1'b0;
    endtask

    initial begin
        aresetn = 1'b0;
        cmd_full = 1'b1;
        awid = '0;
        awaddr = '0;
        awlen = '0;
        awsize = '0;
        awburst = '0;
        awvalid = 1'b0;
        wdata = '0;
        wstrb = '0;
        wlast = 1'b0;
        wvalid = 1'b0;
        arid = '0;
        araddr = '0;
        arlen = '0;
        arsize = '0;
        arburst = '0;
        arvalid = 1'b0;
        repeat (16) begin
            @(posedge aclk);
        end
        #1;
        aresetn = 1'b1;

        // fifo reports full through reset, so nothing is ready yet
        @(negedge aclk);
        if (awready || wready || arready || cmd_push) begin
            errors++;
            $display("Error at time %0t: ready or push high in the first cycle after reset",
                     $time);
        end
        @(posedge aclk);
        #1;
        cmd_full = 1'b0;
        @(negedge aclk);
        if (!awready || !arready || wready) begin
            errors++;
            $display("Error at time %0t: idle ready signals wrong once cmd_full fell", $time);
        end
        @(posedge aclk);
        #1;

        write_burst(8'h3c, 32'h1000_0040, 8'd3, 3'd3, 1'b0);
        check_cmds("write burst");

        write_burst(8'h17, 32'h0000_2000, 8'd3, 3'd3, 1'b1);
        check_cmds("strobed write");

        expect_read(8'h5a, 32'h3000_0010, 8'd5, 3'd2);
        send_ar(8'h5a, 32'h3000_0010, 8'd5, 3'd2);
        check_cmds("read burst");

        full_run = 1'b1;
        fork
            begin
                expect_read(8'h21, 32'h0000_4000, 8'd7, 3'd2);
                send_ar(8'h21, 32'h0000_4000, 8'd7, 3'd2);
                write_burst(8'h22, 32'h0000_5000, 8'd5, 3'd3, 1'b1);
                check_cmds("back-pressure");
                full_run = 1'b0;
            end
            toggle_full();
        join

        // both address channels valid at once
        fork
            write_burst(8'h31, 32'h0000_6000, 8'd2, 3'd3, 1'b0);
            send_ar(8'h32, 32'h0000_7000, 8'd1, 3'd1);
        join
        expect_read(8'h32, 32'h0000_7000, 8'd1, 3'd1);
        check_cmds("write priority");

        $display("Checks done: %0d errors, %0d timeouts", errors + push_errors, timeouts);
        if (errors + push_errors + timeouts == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule
